//--- flist.f
pio_isa_pkg.sv
pio_cfg_pkg.sv
pio_tx_buffer.sv
pio_fetch.sv
pio_shift_regs.sv
pio_execute.sv
pio_sm_top.sv
tb_pio.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_pio -f flist.f -o sim_pio
./obj_dir/sim_pio | tee sim.log
if grep -q "all tests passed" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

//--- tb_pio.sv
// Testbench for the PIO state machine
// Program loader, credit source and sink, six directed tests
`default_nettype none

module tb_pio;

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic enable = 1'b0;
  pio_cfg_pkg::sm_cfg_t cfg = '0;
  logic prog_we = 1'b0;
  pio_isa_pkg::prog_addr_t prog_addr = '0;
  pio_isa_pkg::instr_t prog_data = '0;
  pio_cfg_pkg::pin_t in_pins = '0;
  logic tx_valid = 1'b0;
  pio_cfg_pkg::word_t tx_data = '0;
  logic rx_credit = 1'b0;
  pio_cfg_pkg::pin_t out_pins;
  logic tx_credit;
  logic rx_valid;
  pio_cfg_pkg::word_t rx_data;

  integer seed = 32'h549;
  int errors = 0;
  int failing = 0;
  int tx_cred;
  int tx_ret;
  int rx_pending;
  logic sink_on = 1'b1;
  pio_cfg_pkg::pin_t pins_prev;
  pio_isa_pkg::instr_t prog [$];
  logic [31:0] tx_q [$];
  logic [31:0] rx_got [$];
  logic [31:0] pins_seen [$];

  pio_sm_top dut0 (
    .clk, .reset, .enable, .cfg, .prog_we, .prog_addr, .prog_data, .in_pins,
    .tx_valid, .tx_data, .rx_credit, .out_pins, .tx_credit, .rx_valid, .rx_data
  );

  always #20 clk = ~clk;

  // Credit source, credit sink and pin change monitor
  always @(posedge clk) begin
    if (reset) begin
      tx_cred = pio_cfg_pkg::TX_DEPTH;
      tx_ret = 0;
      rx_pending = 0;
      pins_prev = '0;
      tx_q.delete();
      rx_got.delete();
      pins_seen.delete();
      tx_valid <= 1'b0;
      rx_credit <= 1'b0;
    end else begin
      if (tx_credit) begin
        tx_cred++;
        tx_ret++;
      end
      if (tx_q.size() > 0 && tx_cred > 0) begin
        tx_valid <= 1'b1;
        tx_data <= tx_q.pop_front();
        tx_cred--;
      end else tx_valid <= 1'b0;
      if (rx_valid) begin
        rx_got.push_back(rx_data);
        rx_pending++;
      end
      if (rx_pending > 0 && sink_on) begin
        rx_credit <= 1'b1;
        rx_pending--;
      end else rx_credit <= 1'b0;
      if (out_pins != pins_prev) pins_seen.push_back({24'd0, out_pins});
      pins_prev = out_pins;
    end
  end

  function automatic pio_isa_pkg::instr_t enc(input pio_isa_pkg::opcode_e op,
                                              input logic [2:0] op1, input logic [4:0] op2);
    return {op, 5'd0, op1, op2};
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  // Resets the DUT, loads prog and applies the configuration
  task automatic start(input logic [4:0] wtop, input logic [2:0] in_base);
    @(posedge clk);
    enable <= 1'b0;
    reset <= 1'b1;
    in_pins <= '0;
    sink_on <= 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    foreach (prog[i]) begin
      @(posedge clk);
      prog_we <= 1'b1;
      prog_addr <= 5'(i);
      prog_data <= prog[i];
    end
    @(posedge clk);
    prog_we <= 1'b0;
    cfg <= '{wrap_bottom: 5'd0, wrap_top: wtop, out_base: 3'd0, out_count: 4'd8,
             set_base: 3'd0, set_count: 3'd5, in_base: in_base, jmp_pin: 3'd0};
  endtask

  // Waits until rx words (0), pin changes (1) or tx credits (2) reach n
  task automatic wait_count(input int which, input int n, input string what);
    int got;
    for (int t = 0; t < 3000; t++) begin
      @(posedge clk);
      got = (which == 0) ? rx_got.size() : (which == 1) ? pins_seen.size() : tx_ret;
      if (got >= n) return;
    end
    $display("%s: timeout, only %0d of %0d events seen", what, got, n);
    $display("tests failed");
    $finish;
  endtask

  task automatic finish_test(input string name, input int err_before);
    enable <= 1'b0;
    if (errors == err_before) $display("test %s: ok", name);
    else begin
      $display("test %s: FAILED with %0d errors", name, errors - err_before);
      failing++;
    end
  endtask

  initial begin
    int e;
    logic [7:0] lb;
    logic [7:0] prev;
    logic [6:0] p;
    logic [5:0] cnt;
    logic [31:0] exp_pins [$];

    // Test 1: SET loop counted down by JMP X--
    e = errors;
    prog = '{enc(pio_isa_pkg::OP_SET, 3'd1, 5'd3), enc(pio_isa_pkg::OP_SET, 3'd0, 5'd5),
             enc(pio_isa_pkg::OP_SET, 3'd0, 5'd10), enc(pio_isa_pkg::OP_JMP, 3'd2, 5'd1),
             enc(pio_isa_pkg::OP_SET, 3'd0, 5'd31), enc(pio_isa_pkg::OP_JMP, 3'd0, 5'd5)};
    start(5'd31, 3'd0);
    enable <= 1'b1;
    wait_count(1, 9, "set_loop");
    exp_pins = '{5, 10, 5, 10, 5, 10, 5, 10, 31};
    foreach (exp_pins[i]) check("set_loop", exp_pins[i], pins_seen[i]);
    finish_test("set_loop", e);

    // Test 2: blocking PULL then OUT pins, words under TX credit
    e = errors;
    prog = '{enc(pio_isa_pkg::OP_PUSHPULL, 3'b101, 5'd0), enc(pio_isa_pkg::OP_OUT, 3'd0, 5'd8)};
    start(5'd1, 3'd0);
    exp_pins.delete();
    prev = 8'd0;
    for (int i = 0; i < 8; i++) begin
      lb = 8'($random(seed));
      while (lb == 8'd0 || lb == prev) lb = lb + 8'd1;
      prev = lb;
      exp_pins.push_back({24'd0, lb});
      tx_q.push_back({24'($random(seed)), lb});
    end
    enable <= 1'b1;
    wait_count(1, 8, "pull_out");
    wait_count(2, 8, "pull_out credits");
    foreach (exp_pins[i]) check("pull_out", exp_pins[i], pins_seen[i]);
    check("pull_out credits", 32'd8, 32'(tx_ret));
    finish_test("pull_out", e);

    // Test 3: two IN pins 7 then PUSH, gated by WAIT on pin 7
    e = errors;
    prog = '{enc(pio_isa_pkg::OP_WAIT, 3'b100, 5'd7), enc(pio_isa_pkg::OP_IN, 3'd0, 5'd7),
             enc(pio_isa_pkg::OP_IN, 3'd0, 5'd7), enc(pio_isa_pkg::OP_PUSHPULL, 3'd0, 5'd0),
             enc(pio_isa_pkg::OP_WAIT, 3'b000, 5'd7)};
    start(5'd4, 3'd0);
    enable <= 1'b1;
    for (int k = 0; k < 4; k++) begin
      p = 7'($random(seed));
      @(posedge clk);
      in_pins <= {1'b1, p};
      wait_count(0, k + 1, "in_push");
      check("in_push", {18'd0, p, p}, rx_got[k]);
      in_pins <= {1'b0, p};
      repeat (3) @(posedge clk);
    end
    finish_test("in_push", e);

    // Test 4: sink withholds RX credits, then returns them
    e = errors;
    prog = '{enc(pio_isa_pkg::OP_JMP, 3'd4, 5'd1), enc(pio_isa_pkg::OP_IN, 3'd2, 5'd0),
             enc(pio_isa_pkg::OP_PUSHPULL, 3'd0, 5'd0)};
    start(5'd2, 3'd0);
    sink_on <= 1'b0;
    enable <= 1'b1;
    wait_count(0, pio_cfg_pkg::RX_CREDITS, "backpressure");
    repeat (20) @(posedge clk);
    check("backpressure held", 32'(pio_cfg_pkg::RX_CREDITS), 32'(rx_got.size()));
    sink_on <= 1'b1;
    wait_count(0, 8, "backpressure");
    for (int k = 0; k < 8; k++) check("backpressure", ~32'(k), rx_got[k]);
    finish_test("backpressure", e);

    // Test 5: WAIT on mapped pin 2 with in_base 3, then push X
    e = errors;
    prog = '{enc(pio_isa_pkg::OP_SET, 3'd1, 5'd13), enc(pio_isa_pkg::OP_WAIT, 3'b101, 5'd2),
             enc(pio_isa_pkg::OP_IN, 3'd1, 5'd0), enc(pio_isa_pkg::OP_PUSHPULL, 3'd0, 5'd0),
             enc(pio_isa_pkg::OP_JMP, 3'd0, 5'd4)};
    start(5'd31, 3'd3);
    enable <= 1'b1;
    repeat (30) @(posedge clk);
    check("wait_pin early", 32'd0, 32'(rx_got.size()));
    in_pins <= 8'h20;
    wait_count(0, 1, "wait_pin");
    check("wait_pin", 32'd13, rx_got[0]);
    finish_test("wait_pin", e);

    // Test 6: non-blocking PULL on empty, OUT, JMP on OSR not empty
    e = errors;
    for (int v = 0; v < 2; v++) begin
      cnt = (v == 0) ? 6'd5 : 6'd32;
      prog = '{enc(pio_isa_pkg::OP_SET, 3'd1, 5'd21),
               enc(pio_isa_pkg::OP_PUSHPULL, 3'b100, 5'd0),
               enc(pio_isa_pkg::OP_OUT, 3'd0, cnt[4:0]), enc(pio_isa_pkg::OP_JMP, 3'd7, 5'd6),
               enc(pio_isa_pkg::OP_SET, 3'd0, 5'd3), enc(pio_isa_pkg::OP_JMP, 3'd0, 5'd5),
               enc(pio_isa_pkg::OP_SET, 3'd0, 5'd12), enc(pio_isa_pkg::OP_JMP, 3'd0, 5'd7)};
      start(5'd31, 3'd0);
      cfg.out_count <= 4'd5;
      enable <= 1'b1;
      wait_count(1, 2, "pull_empty");
      check("pull_empty out", 32'd21, pins_seen[0]);
      check("pull_empty jmp", (cnt == 6'd32) ? 32'd3 : 32'd12, pins_seen[1]);
    end
    finish_test("pull_empty", e);

    @(posedge clk);
    $display("totals: 6 tests, %0d failing, %0d errors", failing, errors);
    if (failing == 0) $display("all tests passed");
    else $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- pio_sm_top.sv
// State machine top level
// Connects fetch, execute, shift registers and the TX buffer
`default_nettype none

module pio_sm_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    enable,
  input  pio_cfg_pkg::sm_cfg_t    cfg,
  input  logic                    prog_we,
  input  pio_isa_pkg::prog_addr_t prog_addr,
  input  pio_isa_pkg::instr_t     prog_data,
  input  pio_cfg_pkg::pin_t       in_pins,
  input  logic                    tx_valid,
  input  pio_cfg_pkg::word_t      tx_data,
  input  logic                    rx_credit,
  output pio_cfg_pkg::pin_t       out_pins,
  output logic                    tx_credit,
  output logic                    rx_valid,
  output pio_cfg_pkg::word_t      rx_data
);

  pio_isa_pkg::fetch_t     fetched;
  logic                    stall;
  logic                    redirect_valid;
  pio_isa_pkg::prog_addr_t redirect_pc;
  logic                    pull;
  logic                    tx_empty;
  pio_cfg_pkg::word_t      tx_word;
  logic                    isr_load;
  logic                    isr_shift;
  logic                    osr_load;
  logic                    osr_shift;
  pio_isa_pkg::op2_t       shift_amt;
  pio_cfg_pkg::word_t      load_data;
  pio_cfg_pkg::word_t      isr;
  pio_cfg_pkg::word_t      osr;
  pio_cfg_pkg::shift_cnt_t osr_count;

  pio_fetch fetch0 (
    .clk, .reset, .enable, .cfg, .prog_we, .prog_addr, .prog_data,
    .stall, .redirect_valid, .redirect_pc, .fetched
  );

  pio_execute exec0 (
    .clk, .reset, .enable, .cfg, .fetched, .in_pins, .tx_empty, .tx_word,
    .isr, .osr, .osr_count, .rx_credit, .stall, .redirect_valid, .redirect_pc,
    .pull, .isr_load, .isr_shift, .osr_load, .osr_shift, .shift_amt, .load_data,
    .rx_valid, .rx_data, .out_pins
  );

  pio_shift_regs shregs0 (
    .clk, .reset, .isr_load, .isr_shift, .osr_load, .osr_shift,
    .shift_amt, .load_data, .isr, .osr, .osr_count
  );

  pio_tx_buffer txbuf0 (
    .clk, .reset, .tx_valid, .tx_data, .pull, .tx_credit, .tx_empty, .tx_word
  );

endmodule

`default_nettype wire

//--- pio_execute.sv
// Execute stage: decode, X/Y, jump conditions, stall and delay
// Also owns the output pins and the RX credit counter
`default_nettype none

module pio_execute (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    enable,
  input  pio_cfg_pkg::sm_cfg_t    cfg,
  input  pio_isa_pkg::fetch_t     fetched,
  input  pio_cfg_pkg::pin_t       in_pins,
  input  logic                    tx_empty,
  input  pio_cfg_pkg::word_t      tx_word,
  input  pio_cfg_pkg::word_t      isr,
  input  pio_cfg_pkg::word_t      osr,
  input  pio_cfg_pkg::shift_cnt_t osr_count,
  input  logic                    rx_credit,
  output logic                    stall,
  output logic                    redirect_valid,
  output pio_isa_pkg::prog_addr_t redirect_pc,
  output logic                    pull,
  output logic                    isr_load,
  output logic                    isr_shift,
  output logic                    osr_load,
  output logic                    osr_shift,
  output pio_isa_pkg::op2_t       shift_amt,
  output pio_cfg_pkg::word_t      load_data,
  output logic                    rx_valid,
  output pio_cfg_pkg::word_t      rx_data,
  output pio_cfg_pkg::pin_t       out_pins
);

  pio_isa_pkg::instr_fields_t ins;
  pio_cfg_pkg::word_t         x;
  pio_cfg_pkg::word_t         y;
  pio_cfg_pkg::word_t         x_next;
  pio_cfg_pkg::word_t         y_next;
  pio_cfg_pkg::pin_t          pins_next;
  pio_cfg_pkg::pin_t          in_rot;
  pio_cfg_pkg::pin_idx_t      wait_idx;
  pio_cfg_pkg::shift_cnt_t    bit_cnt;
  pio_cfg_pkg::word_t         field_mask;
  pio_cfg_pkg::word_t         out_data;
  pio_isa_pkg::delay_t        delay_cnt;
  pio_cfg_pkg::credit_t       rx_cnt;
  logic                       delaying;
  logic                       active;
  logic                       blocked;
  logic                       exec_now;
  logic                       push;

  // Writes count bits of data from pin base upward, wrapping mod 8
  function automatic pio_cfg_pkg::pin_t pin_write(input pio_cfg_pkg::pin_t cur,
                                                  input pio_cfg_pkg::word_t data,
                                                  input pio_cfg_pkg::pin_idx_t base,
                                                  input logic [3:0] count);
    pio_cfg_pkg::pin_t res;
    res = cur;
    for (int i = 0; i < pio_cfg_pkg::NUM_PINS; i++) begin
      if (i < count) res[base + pio_cfg_pkg::pin_idx_t'(i)] = data[i];
    end
    return res;
  endfunction

  assign ins         = pio_isa_pkg::instr_fields_t'(fetched.instr);
  assign in_rot      = pio_cfg_pkg::pin_t'({in_pins, in_pins} >> cfg.in_base);
  assign wait_idx    = ins.op1[0] ? cfg.in_base + pio_cfg_pkg::pin_idx_t'(ins.op2)
                                  : pio_cfg_pkg::pin_idx_t'(ins.op2);
  assign bit_cnt     = (ins.op2 == '0) ? 6'd32 : {1'b0, ins.op2};
  assign field_mask  = pio_cfg_pkg::word_t'((64'd1 << bit_cnt) - 64'd1);
  assign out_data    = osr & field_mask;
  assign shift_amt   = ins.op2;
  assign redirect_pc = ins.op2;

  assign delaying = (delay_cnt != '0);
  assign active   = fetched.valid && !delaying;
  assign exec_now = enable && active && !blocked;
  // Fetch advances on the last delay cycle so the next instruction is ready
  assign stall    = delaying ? (delay_cnt > 5'd1) : (active && (blocked || ins.delay != '0));

  always_comb begin
    blocked = 1'b0;
    case (ins.op)
      pio_isa_pkg::OP_WAIT: begin
        if (!ins.op1[1]) blocked = (in_pins[wait_idx] != ins.op1[2]);  // GPIO or mapped pin
      end
      pio_isa_pkg::OP_PUSHPULL: begin
        if (ins.op1[2]) blocked = ins.op1[0] && tx_empty;  // Blocking PULL
        else blocked = (rx_cnt == '0);  // PUSH waits for a credit
      end
      default: ;
    endcase
  end

  always_comb begin
    redirect_valid = 1'b0;
    push           = 1'b0;
    pull           = 1'b0;
    isr_load       = 1'b0;
    isr_shift      = 1'b0;
    osr_load       = 1'b0;
    osr_shift      = 1'b0;
    load_data      = '0;
    x_next         = x;
    y_next         = y;
    pins_next      = out_pins;
    if (exec_now) begin
      case (ins.op)
        pio_isa_pkg::OP_JMP: begin
          case (ins.op1)
            pio_isa_pkg::JMP_ALWAYS: redirect_valid = 1'b1;
            pio_isa_pkg::JMP_X_ZERO: redirect_valid = (x == '0);
            pio_isa_pkg::JMP_X_DEC: begin
              redirect_valid = (x != '0);  // Tested before the decrement
              x_next         = x - 1'b1;
            end
            pio_isa_pkg::JMP_Y_ZERO: redirect_valid = (y == '0);
            pio_isa_pkg::JMP_Y_DEC: begin
              redirect_valid = (y != '0);
              y_next         = y - 1'b1;
            end
            pio_isa_pkg::JMP_X_NE_Y: redirect_valid = (x != y);
            pio_isa_pkg::JMP_PIN:    redirect_valid = in_pins[cfg.jmp_pin];
            pio_isa_pkg::JMP_OSR_NE: redirect_valid = (osr_count < pio_cfg_pkg::OSR_EMPTY);
          endcase
        end
        pio_isa_pkg::OP_IN: begin
          isr_shift = 1'b1;
          case (ins.op1)
            pio_isa_pkg::SD_PINS: load_data = pio_cfg_pkg::word_t'(in_rot);
            pio_isa_pkg::SD_X:    load_data = x;
            pio_isa_pkg::SD_Y:    load_data = y;
            default:              load_data = '0;  // NULL
          endcase
          load_data = load_data & field_mask;
        end
        pio_isa_pkg::OP_OUT: begin
          osr_shift = 1'b1;
          case (ins.op1)
            pio_isa_pkg::SD_PINS:
              pins_next = pin_write(out_pins, out_data, cfg.out_base, cfg.out_count);
            pio_isa_pkg::SD_X: x_next = out_data;
            pio_isa_pkg::SD_Y: y_next = out_data;
            default: ;  // NULL drops the bits
          endcase
        end
        pio_isa_pkg::OP_PUSHPULL: begin
          if (!ins.op1[2]) begin
            push     = 1'b1;
            isr_load = 1'b1;
          end else if (!tx_empty) begin
            pull      = 1'b1;
            osr_load  = 1'b1;
            load_data = tx_word;
          end else begin
            osr_load  = 1'b1;  // Non-blocking PULL on empty takes X
            load_data = x;
          end
        end
        pio_isa_pkg::OP_SET: begin
          case (ins.op1)
            pio_isa_pkg::SD_PINS:
              pins_next = pin_write(out_pins, pio_cfg_pkg::word_t'(ins.op2), cfg.set_base,
                                    {1'b0, cfg.set_count});
            pio_isa_pkg::SD_X: x_next = pio_cfg_pkg::word_t'(ins.op2);
            pio_isa_pkg::SD_Y: y_next = pio_cfg_pkg::word_t'(ins.op2);
            default: ;
          endcase
        end
        default: ;  // WAIT has no effect once released, MOV and IRQ unsupported
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      x         <= '0;
      y         <= '0;
      out_pins  <= '0;
      delay_cnt <= '0;
      rx_valid  <= 1'b0;
      rx_cnt    <= pio_cfg_pkg::credit_t'(pio_cfg_pkg::RX_CREDITS);
    end else begin
      x        <= x_next;
      y        <= y_next;
      out_pins <= pins_next;
      if (enable) begin
        if (delaying) delay_cnt <= delay_cnt - 1'b1;
        else if (exec_now) delay_cnt <= ins.delay;
      end
      rx_valid <= push;
      rx_cnt   <= rx_cnt + pio_cfg_pkg::credit_t'(rx_credit) - pio_cfg_pkg::credit_t'(push);
    end
  end

  always_ff @(posedge clk) begin
    if (push) rx_data <= isr;  // ISR before its clear
  end

  // Every word handed to the sink was covered by a credit
  a_rx_credit: assert property (@(posedge clk) disable iff (reset)
    rx_valid |-> $past(rx_cnt) != '0);

  // Sink never returns more credits than words it received
  a_rx_credit_bound: assert property (@(posedge clk) disable iff (reset)
    rx_cnt <= pio_cfg_pkg::credit_t'(pio_cfg_pkg::RX_CREDITS));

endmodule

`default_nettype wire

//--- pio_shift_regs.sv
// Input and output shift registers
// ISR shifts left, OSR shifts right and counts the bits sent
`default_nettype none

module pio_shift_regs (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    isr_load,
  input  logic                    isr_shift,
  input  logic                    osr_load,
  input  logic                    osr_shift,
  input  pio_isa_pkg::op2_t       shift_amt,
  input  pio_cfg_pkg::word_t      load_data,
  output pio_cfg_pkg::word_t      isr,
  output pio_cfg_pkg::word_t      osr,
  output pio_cfg_pkg::shift_cnt_t osr_count
);

  pio_cfg_pkg::shift_cnt_t n;
  logic [6:0]              count_sum;

  assign n         = (shift_amt == '0) ? 6'd32 : {1'b0, shift_amt};  // 0 encodes 32
  assign count_sum = osr_count + n;

  // ISR, new bits enter at bit 0
  always_ff @(posedge clk) begin
    if (reset || isr_load) begin
      isr <= '0;
    end else if (isr_shift) begin
      isr <= (isr << n) | load_data;  // load_data arrives masked to n bits
    end
  end

  // OSR and its shift count
  always_ff @(posedge clk) begin
    if (reset) begin
      osr       <= '0;
      osr_count <= pio_cfg_pkg::OSR_EMPTY;
    end else if (osr_load) begin
      osr       <= load_data;
      osr_count <= '0;
    end else if (osr_shift) begin
      osr <= osr >> n;
      if (count_sum > 7'(pio_cfg_pkg::OSR_EMPTY)) begin
        osr_count <= pio_cfg_pkg::OSR_EMPTY;  // Saturate at empty
      end else begin
        osr_count <= count_sum[5:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- pio_fetch.sv
// Program memory, program counter with wrap and the fetch register
// Runs one instruction ahead of execute
`default_nettype none

module pio_fetch (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    enable,
  input  pio_cfg_pkg::sm_cfg_t    cfg,
  input  logic                    prog_we,
  input  pio_isa_pkg::prog_addr_t prog_addr,
  input  pio_isa_pkg::instr_t     prog_data,
  input  logic                    stall,
  input  logic                    redirect_valid,
  input  pio_isa_pkg::prog_addr_t redirect_pc,
  output pio_isa_pkg::fetch_t     fetched
);

  pio_isa_pkg::instr_t     mem [pio_isa_pkg::PROG_DEPTH];
  pio_isa_pkg::prog_addr_t pc;
  pio_isa_pkg::prog_addr_t fetch_pc;
  pio_isa_pkg::prog_addr_t next_pc;
  logic                    started;  // First fetch done since reset or load

  // Before the first fetch the PC follows wrap_bottom, so cfg may change late
  assign fetch_pc = started ? pc : cfg.wrap_bottom;

  // Wrap predicted here at no bubble cost
  assign next_pc = (fetch_pc == cfg.wrap_top) ? cfg.wrap_bottom : fetch_pc + 1'b1;

  always_ff @(posedge clk) begin
    if (prog_we) mem[prog_addr] <= prog_data;
  end

  always_ff @(posedge clk) begin
    if (reset || prog_we) begin
      pc            <= cfg.wrap_bottom;
      started       <= 1'b0;
      fetched.valid <= 1'b0;
    end else if (enable) begin
      if (redirect_valid) begin
        fetched.valid <= 1'b0;  // Drop the wrong-path instruction
        pc            <= redirect_pc;
        started       <= 1'b1;
      end else if (!stall) begin
        fetched.valid <= 1'b1;
        fetched.pc    <= fetch_pc;
        fetched.instr <= mem[fetch_pc];
        pc            <= next_pc;
        started       <= 1'b1;
      end
    end
  end

  // First instruction fetched after a taken jump comes from the jump target
  a_redirect_target: assert property (@(posedge clk) disable iff (reset || prog_we)
    $past(enable && redirect_valid && !reset && !prog_we, 2)
      && $past(enable && !stall && !reset && !prog_we)
      |-> fetched.valid && fetched.pc == $past(redirect_pc, 2));

endmodule

`default_nettype wire

//--- pio_tx_buffer.sv
// TX word buffer, filled under credit from the source
// Returns one credit per word pulled by the state machine
`default_nettype none

module pio_tx_buffer (
  input  logic               clk,
  input  logic               reset,
  input  logic               tx_valid,
  input  pio_cfg_pkg::word_t tx_data,
  input  logic               pull,
  output logic               tx_credit,
  output logic               tx_empty,
  output pio_cfg_pkg::word_t tx_word
);

  pio_cfg_pkg::word_t                       mem [pio_cfg_pkg::TX_DEPTH];
  logic [$clog2(pio_cfg_pkg::TX_DEPTH)-1:0] wr_ptr;
  logic [$clog2(pio_cfg_pkg::TX_DEPTH)-1:0] rd_ptr;
  pio_cfg_pkg::credit_t                     count;

  assign tx_empty = (count == '0);
  assign tx_word  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (tx_valid) mem[wr_ptr] <= tx_data;
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      tx_credit <= 1'b0;
    end else begin
      if (tx_valid) wr_ptr <= wr_ptr + 1'b1;
      if (pull) rd_ptr <= rd_ptr + 1'b1;
      count     <= count + pio_cfg_pkg::credit_t'(tx_valid) - pio_cfg_pkg::credit_t'(pull);
      tx_credit <= pull;  // Credit back one cycle after the pull
    end
  end

  // Source sends only on a held credit, so a full buffer never sees a word
  a_tx_no_overflow: assert property (@(posedge clk) disable iff (reset)
    tx_valid |-> count != pio_cfg_pkg::credit_t'(pio_cfg_pkg::TX_DEPTH));

  // Execute must see tx_empty before pulling
  a_tx_no_underflow: assert property (@(posedge clk) disable iff (reset)
    pull |-> !tx_empty);

endmodule

`default_nettype wire

//--- pio_cfg_pkg.sv
// Pin, data and credit types of the state machine
// Configuration struct set by the host
`default_nettype none

package pio_cfg_pkg;

  localparam int NUM_PINS   = 8;
  localparam int TX_DEPTH   = 4;
  localparam int RX_CREDITS = 4;

  typedef logic [NUM_PINS-1:0] pin_t;
  typedef logic [2:0]          pin_idx_t;
  typedef logic [31:0]         word_t;
  typedef logic [5:0]          shift_cnt_t;
  typedef logic [2:0]          credit_t;

  localparam shift_cnt_t OSR_EMPTY = 6'd32;  // Shift count of a drained OSR

  typedef struct packed {
    pio_isa_pkg::prog_addr_t wrap_bottom;
    pio_isa_pkg::prog_addr_t wrap_top;
    pin_idx_t                out_base;
    logic [3:0]              out_count;
    pin_idx_t                set_base;
    logic [2:0]              set_count;
    pin_idx_t                in_base;
    pin_idx_t                jmp_pin;
  } sm_cfg_t;

endpackage

`default_nettype wire

//--- pio_isa_pkg.sv
// Instruction encoding of the PIO state machine
// Opcodes, operand values, field types and the fetch-to-execute bundle
`default_nettype none

package pio_isa_pkg;

  localparam int PROG_DEPTH = 32;

  typedef logic [15:0] instr_t;
  typedef logic [4:0]  prog_addr_t;
  typedef logic [4:0]  delay_t;
  typedef logic [2:0]  op1_t;  // Condition, source or destination
  typedef logic [4:0]  op2_t;  // Address, bit count, data or index

  typedef enum logic [2:0] {
    OP_JMP      = 3'd0,
    OP_WAIT     = 3'd1,
    OP_IN       = 3'd2,
    OP_OUT      = 3'd3,
    OP_PUSHPULL = 3'd4,
    OP_MOV      = 3'd5,  // No-op here
    OP_IRQ      = 3'd6,  // No-op here
    OP_SET      = 3'd7
  } opcode_e;

  // JMP conditions
  localparam op1_t JMP_ALWAYS = 3'd0;
  localparam op1_t JMP_X_ZERO = 3'd1;
  localparam op1_t JMP_X_DEC  = 3'd2;
  localparam op1_t JMP_Y_ZERO = 3'd3;
  localparam op1_t JMP_Y_DEC  = 3'd4;
  localparam op1_t JMP_X_NE_Y = 3'd5;
  localparam op1_t JMP_PIN    = 3'd6;
  localparam op1_t JMP_OSR_NE = 3'd7;

  // Sources and destinations shared by IN, OUT and SET
  localparam op1_t SD_PINS = 3'd0;
  localparam op1_t SD_X    = 3'd1;
  localparam op1_t SD_Y    = 3'd2;

  typedef struct packed {
    opcode_e op;
    delay_t  delay;
    op1_t    op1;
    op2_t    op2;
  } instr_fields_t;

  typedef struct packed {
    logic       valid;
    prog_addr_t pc;
    instr_t     instr;
  } fetch_t;

endpackage

`default_nettype wire
